//--- cpu16_backend.f
verilog/cpu16_pkg.sv
verilog/issue_unit.sv
verilog/exec_lane.sv
verilog/data_mem.sv
verilog/writeback_unit.sv
verilog/cpu16_backend.sv
tests/clock_gen.sv
tests/tb_cpu16_backend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the cpu16 backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_cpu16_backend \
    -Mdir obj_dir \
    -f cpu16_backend.f
if [ $? -ne 0 ]; then
    echo "verilator build did not succeed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_cpu16_backend)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

//--- data_mem.hex
// one 16-bit data word per line for addresses 0 to 15
1000
1011
1022
1033
1044
1055
1066
1077
1088
1099
10aa
10bb
10cc
10dd
10ee
10ff

//--- tests/tb_cpu16_backend.sv
`timescale 1ns/100ps

module tb_cpu16_backend
    import cpu16_pkg::*;
();

    localparam int WATCHDOG_MARGIN = 200;
    localparam int RAND_COUNT      = 24;

    logic    clk;
    logic    reset;
    logic    in_valid;
    logic    in_ready;
    instr_t  in_instr;
    logic    retire_valid;
    logic    retire_ready;
    retire_t retire;
    regval_t regval;

    word_t   model_regs [NUM_REGS];
    retire_t expected_q [$];
    string   cur_test;
    integer  seed;
    logic    rand_ready;
    int      issued;
    int      checks;
    int      errors;
    int      test_errors;
    int      tests;

    clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    cpu16_backend u_cpu16_backend (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_instr     (in_instr),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire),
        .regval       (regval)
    );

    // memory image holds 0x1000 + 0x11 * addr below 16 and zero elsewhere
    function automatic word_t mem_word(input logic [7:0] addr);
        if (addr < 8'd16)
            return 16'h1000 + 16'h0011 * {8'h00, addr};
        else
            return 16'h0000;
    endfunction

    function automatic instr_t alu_instr(input logic [3:0] op, input logic [2:0] rd,
                                         input logic [2:0] rs1, input logic [2:0] rs2);
        return {op, 1'b0, rd, rs1, rs2, 2'b00};
    endfunction

    function automatic instr_t ldi_instr(input logic [2:0] rd, input logic [7:0] imm);
        return {OP_LDI, 1'b0, rd, imm};
    endfunction

    function automatic instr_t ld_instr(input logic [2:0] rd, input logic [2:0] rs1,
                                        input logic [4:0] imm);
        return {OP_LD, 1'b0, rd, rs1, imm};
    endfunction

    function automatic regval_t model_regval();
        regval_t rv;
        for (int i = 0; i < NUM_REGS; i++) begin
            rv[i*16 +: 16] = model_regs[i];
        end
        return rv;
    endfunction

    // reference model runs in program order as instructions are sent
    task automatic predict(input instr_t instr);
        logic [3:0] op;
        word_t      a;
        word_t      b;
        word_t      res;
        logic       wr;
        retire_t    want;
        op = instr[15:12];
        a  = model_regs[instr[7:5]];
        b  = model_regs[instr[4:2]];
        wr = 1'b1;
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SHL:  res = a << b[3:0];
            OP_LDI:  res = {8'h00, instr[7:0]};
            OP_LD:   res = mem_word(a[7:0] + {3'b000, instr[4:0]});
            default: begin
                res = 16'h0000;
                wr  = 1'b0;
            end
        endcase
        if (wr)
            model_regs[instr[10:8]] = res;
        want.instr   = instr;
        want.written = wr;
        want.result  = res;
        expected_q.push_back(want);
    endtask

    task automatic check(input string what, input logic [127:0] expected,
                         input logic [127:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: %s expected %0h actual %0h", cur_test, what, expected, actual);
        end
    endtask

    task automatic send(input instr_t instr);
        predict(instr);
        issued++;
        @(posedge clk);
        in_valid <= 1'b1;
        in_instr <= instr;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_idle();
        while (expected_q.size() != 0)
            @(negedge clk);
        @(negedge clk);
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("%-22s %0d mismatches", cur_test, errors - test_errors);
    endtask

    task automatic reset_state();
        begin_test("reset_state");
        check("in_ready", 128'd1, 128'(in_ready));
        check("retire_valid", 128'd0, 128'(retire_valid));
        check("regval", '0, regval);
        end_test();
    endtask

    task automatic ldi_all_regs();
        logic [7:0] imm;
        begin_test("ldi_all_regs");
        imm = 8'h30;
        for (int r = 0; r < NUM_REGS; r++) begin
            send(ldi_instr(3'(r), imm));
            imm = imm + 8'h13;
        end
        wait_idle();
        check("regval", model_regval(), regval);
        end_test();
    endtask

    // each op reads the register the one before it wrote
    task automatic alu_chain();
        begin_test("alu_chain");
        send(alu_instr(OP_ADD, 3'd1, 3'd0, 3'd2));
        send(alu_instr(OP_SUB, 3'd2, 3'd1, 3'd3));
        send(alu_instr(OP_AND, 3'd3, 3'd2, 3'd4));
        send(alu_instr(OP_OR,  3'd4, 3'd3, 3'd5));
        send(alu_instr(OP_XOR, 3'd5, 3'd4, 3'd6));
        send(alu_instr(OP_SHL, 3'd6, 3'd5, 3'd7));
        send(alu_instr(OP_NOP, 3'd0, 3'd6, 3'd6));
        // unassigned code with rd set must leave r7 alone
        send(alu_instr(4'ha, 3'd7, 3'd6, 3'd1));
        wait_idle();
        check("regval", model_regval(), regval);
        end_test();
    endtask

    task automatic load_patterns();
        begin_test("loads");
        send(ldi_instr(3'd1, 8'h00));
        send(ldi_instr(3'd2, 8'h05));
        send(ldi_instr(3'd3, 8'h0c));
        send(ldi_instr(3'd4, 8'hf8));
        send(ld_instr(3'd5, 3'd1, 5'd3));
        send(ld_instr(3'd6, 3'd2, 5'd10));
        // address 16 is past the image
        send(ld_instr(3'd7, 3'd3, 5'd4));
        // 0xf8 + 8 wraps to address 0
        send(ld_instr(3'd0, 3'd4, 5'd8));
        send(ld_instr(3'd5, 3'd4, 5'd31));
        send(ld_instr(3'd6, 3'd1, 5'd0));
        wait_idle();
        check("regval", model_regval(), regval);
        end_test();
    endtask

    task automatic random_retire_ready();
        instr_t      prog [RAND_COUNT];
        logic [31:0] r;
        logic [3:0]  op;
        begin_test("random_retire_ready");
        for (int i = 0; i < RAND_COUNT; i++) begin
            r  = $random(seed);
            op = (r[5:3] == 3'd7) ? OP_NOP : {1'b0, r[2:0]};
            prog[i] = {op, r[27:16]};
        end
        rand_ready = 1'b1;
        for (int i = 0; i < RAND_COUNT; i++) begin
            send(prog[i]);
        end
        wait_idle();
        rand_ready = 1'b0;
        check("regval", model_regval(), regval);
        end_test();
    endtask

    task automatic idle_latency();
        int   latency;
        logic seen;
        begin_test("idle_latency");
        send(ldi_instr(3'd3, 8'h5a));
        latency = 0;
        seen    = 1'b0;
        while (!seen && latency < 20) begin
            @(posedge clk);
            latency++;
            @(negedge clk);
            seen = retire_valid;
        end
        check("retire latency", 128'd4, 128'(latency));
        wait_idle();
        check("regval", model_regval(), regval);
        end_test();
    endtask

    // a retire transfers on the posedge after a negedge with valid and ready high
    initial begin : retire_monitor
        retire_t want;
        forever begin
            @(negedge clk);
            if (retire_valid && retire_ready) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("%s: an instruction retired that was never issued", cur_test);
                end else begin
                    want = expected_q.pop_front();
                    check("retired instr", 128'(want.instr), 128'(retire.instr));
                    check("written flag", 128'(want.written), 128'(retire.written));
                    check("result", 128'(want.result), 128'(retire.result));
                end
            end
        end
    end

    initial begin : ready_driver
        logic [31:0] r;
        retire_ready <= 1'b1;
        forever begin
            @(posedge clk);
            if (rand_ready) begin
                r = $random(seed);
                retire_ready <= r[0];
            end else begin
                retire_ready <= 1'b1;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 20 * issued + WATCHDOG_MARGIN) begin
            @(posedge clk);
            cycles++;
        end
        $display("watchdog expired after %0d cycles with %0d instructions sent", cycles, issued);
        $display("Test failed");
        $finish;
    end

    initial begin
        in_valid   <= 1'b0;
        in_instr   <= '0;
        rand_ready = 1'b0;
        seed       = 32'hda44;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        @(negedge clk);
        while (reset !== 1'b0)
            @(negedge clk);

        reset_state();
        ldi_all_regs();
        alu_chain();
        load_patterns();
        random_retire_ready();
        idle_latency();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tests/clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- verilog/cpu16_backend.sv
`timescale 1ns/100ps

module cpu16_backend
    import cpu16_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    in_valid,
    output logic    in_ready,
    input  instr_t  in_instr,
    output logic    retire_valid,
    input  logic    retire_ready,
    output retire_t retire,
    output regval_t regval
);

    logic [NUM_LANES-1:0] lane_in_valid;
    logic [NUM_LANES-1:0] lane_in_ready;
    issue_t               lane_in [NUM_LANES];
    logic [NUM_LANES-1:0] lane_out_valid;
    logic [NUM_LANES-1:0] lane_out_ready;
    lane_result_t         lane_out [NUM_LANES];
    mem_addr_t            mem_addr [NUM_LANES];
    word_t                mem_data [NUM_LANES];
    commit_t              commit;

    issue_unit u_issue_unit (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_instr      (in_instr),
        .regval        (regval),
        .commit        (commit),
        .lane_in_valid (lane_in_valid),
        .lane_in_ready (lane_in_ready),
        .lane_in       (lane_in)
    );

    // identical lanes fed in strict rotation
    genvar g;
    generate
        for (g = 0; g < NUM_LANES; g++) begin : g_lane
            exec_lane u_exec_lane (
                .clk       (clk),
                .reset     (reset),
                .in_valid  (lane_in_valid[g]),
                .in_ready  (lane_in_ready[g]),
                .in_op     (lane_in[g]),
                .mem_addr  (mem_addr[g]),
                .mem_data  (mem_data[g]),
                .out_valid (lane_out_valid[g]),
                .out_ready (lane_out_ready[g]),
                .out_res   (lane_out[g])
            );
        end
    endgenerate

    data_mem u_data_mem (
        .clk   (clk),
        .addr  (mem_addr),
        .rdata (mem_data)
    );

    writeback_unit u_writeback_unit (
        .clk            (clk),
        .reset          (reset),
        .lane_out_valid (lane_out_valid),
        .lane_out_ready (lane_out_ready),
        .lane_out       (lane_out),
        .retire_valid   (retire_valid),
        .retire_ready   (retire_ready),
        .retire         (retire),
        .regval         (regval),
        .commit         (commit)
    );

endmodule

//--- verilog/writeback_unit.sv
`timescale 1ns/100ps

module writeback_unit
    import cpu16_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_LANES-1:0] lane_out_valid,
    output logic [NUM_LANES-1:0] lane_out_ready,
    input  lane_result_t         lane_out [NUM_LANES],
    output logic                 retire_valid,
    input  logic                 retire_ready,
    output retire_t              retire,
    output regval_t              regval,
    output commit_t              commit
);

    lane_idx_t    drain_ptr;
    lane_result_t head;
    word_t        head_result;
    logic         can_take;
    logic         drain;
    word_t        regs [NUM_REGS];

    // draining only the lane under the pointer keeps program order
    assign head        = lane_out[drain_ptr];
    assign head_result = head.isld ? head.ldresult : head.aluresult;
    assign can_take    = !retire_valid || retire_ready;
    assign drain       = lane_out_valid[drain_ptr] && can_take;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_out_ready[i] = can_take && (drain_ptr == lane_idx_t'(i));
        end
    end

    // register write and scoreboard release on the drain edge
    assign commit.valid = drain && head.iswb;
    assign commit.idx   = rd_of(head.instr);
    assign commit.value = head_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            drain_ptr <= '0;
        end else if (drain) begin
            if (drain_ptr == lane_idx_t'(NUM_LANES - 1))
                drain_ptr <= '0;
            else
                drain_ptr <= drain_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit.valid) begin
            regs[commit.idx] <= commit.value;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_REGS; i++) begin
            regval[i*WORD_W +: WORD_W] = regs[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else if (drain) begin
            retire_valid <= 1'b1;
        end else if (retire_ready) begin
            retire_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (drain) begin
            retire.instr   <= head.instr;
            retire.written <= head.iswb;
            retire.result  <= head_result;
        end
    end

    a_retire_stable: assert property (
        @(posedge clk) disable iff (reset)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire)
    );

endmodule

//--- verilog/data_mem.sv
`timescale 1ns/100ps

module data_mem
    import cpu16_pkg::*;
(
    input  logic      clk,
    input  mem_addr_t addr  [NUM_LANES],
    output word_t     rdata [NUM_LANES]
);

    word_t mem [MEM_WORDS];

    // words the image file leaves out read back as zero
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
        $readmemh("data_mem.hex", mem);
    end

    // one independent read port per lane
    genvar g;
    generate
        for (g = 0; g < NUM_LANES; g++) begin : g_port
            always_ff @(posedge clk) begin
                rdata[g] <= mem[addr[g]];
            end
        end
    endgenerate

endmodule

//--- verilog/exec_lane.sv
`timescale 1ns/100ps

module exec_lane
    import cpu16_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    output logic         in_ready,
    input  issue_t       in_op,
    output mem_addr_t    mem_addr,
    input  word_t        mem_data,
    output logic         out_valid,
    input  logic         out_ready,
    output lane_result_t out_res
);

    typedef enum logic [1:0] {
        MEM_EMPTY,
        MEM_READ,
        MEM_DONE
    } mem_state_t;

    logic       ex_valid;
    issue_t     ex_op;
    word_t      alu;
    mem_state_t mem_state;
    logic       mem_accept;
    logic       out_xfer;

    assign out_valid  = (mem_state == MEM_DONE);
    assign out_xfer   = out_valid && out_ready;
    assign mem_accept = ex_valid && (mem_state == MEM_EMPTY || out_xfer);
    assign in_ready   = !ex_valid || mem_accept;

    // execute stage forms the ALU result and load address from the held operands
    always_comb begin
        case (op_of(ex_op.instr))
            OP_ADD:  alu = ex_op.a + ex_op.b;
            OP_SUB:  alu = ex_op.a - ex_op.b;
            OP_AND:  alu = ex_op.a & ex_op.b;
            OP_OR:   alu = ex_op.a | ex_op.b;
            OP_XOR:  alu = ex_op.a ^ ex_op.b;
            OP_SHL:  alu = ex_op.a << ex_op.b[3:0];
            OP_LDI:  alu = {8'h00, imm8_of(ex_op.instr)};
            default: alu = '0;
        endcase
    end

    // address wraps within the 256-word memory
    assign mem_addr = ex_op.a[7:0] + {3'b000, imm5_of(ex_op.instr)};

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            ex_valid <= 1'b1;
        end else if (mem_accept) begin
            ex_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            ex_op <= in_op;
    end

    // memory stage waits one cycle for the synchronous read
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_state <= MEM_EMPTY;
        end else if (mem_accept) begin
            mem_state <= MEM_READ;
        end else if (mem_state == MEM_READ) begin
            mem_state <= MEM_DONE;
        end else if (out_xfer) begin
            mem_state <= MEM_EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_accept) begin
            out_res.instr     <= ex_op.instr;
            out_res.iswb      <= ex_op.iswb;
            out_res.isld      <= ex_op.isld;
            out_res.aluresult <= alu;
            out_res.ldresult  <= '0;
        end else if (mem_state == MEM_READ && out_res.isld) begin
            out_res.ldresult <= mem_data;
        end
    end

    a_out_stable: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_res)
    );

endmodule

//--- verilog/issue_unit.sv
`timescale 1ns/100ps

module issue_unit
    import cpu16_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  instr_t               in_instr,
    input  regval_t              regval,
    input  commit_t              commit,
    output logic [NUM_LANES-1:0] lane_in_valid,
    input  logic [NUM_LANES-1:0] lane_in_ready,
    output issue_t               lane_in [NUM_LANES]
);

    opcode_t             op;
    reg_idx_t            rd;
    reg_idx_t            rs1;
    reg_idx_t            rs2;
    logic                use_rs1;
    logic                use_rs2;
    logic                iswb;
    logic                isld;
    logic [NUM_REGS-1:0] named;
    logic                hazard;
    logic                accept;

    logic [NUM_REGS-1:0] pending;
    logic [NUM_REGS-1:0] pending_next;
    lane_idx_t           rr_ptr;
    lane_idx_t           disp_lane;
    logic                disp_valid;
    issue_t              disp_op;
    logic                disp_use_a;
    logic                disp_use_b;
    logic                disp_xfer;

    assign op  = op_of(in_instr);
    assign rd  = rd_of(in_instr);
    assign rs1 = rs1_of(in_instr);
    assign rs2 = rs2_of(in_instr);

    // decode which register fields the head instruction really uses
    always_comb begin
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        iswb    = 1'b0;
        isld    = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                iswb    = 1'b1;
            end
            OP_LDI: begin
                iswb = 1'b1;
            end
            OP_LD: begin
                use_rs1 = 1'b1;
                iswb    = 1'b1;
                isld    = 1'b1;
            end
            default: begin
                iswb = 1'b0;
            end
        endcase
    end

    always_comb begin
        named = '0;
        if (use_rs1)
            named[rs1] = 1'b1;
        if (use_rs2)
            named[rs2] = 1'b1;
        if (iswb)
            named[rd] = 1'b1;
    end

    assign hazard    = |(named & pending);
    assign disp_xfer = disp_valid && lane_in_ready[disp_lane];
    assign in_ready  = !hazard && (!disp_valid || disp_xfer);
    assign accept    = in_valid && in_ready;

    // commit of the producer frees its destination
    always_comb begin
        pending_next = pending;
        if (commit.valid)
            pending_next[commit.idx] = 1'b0;
        if (accept && iswb)
            pending_next[rd] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending    <= '0;
            rr_ptr     <= '0;
            disp_valid <= 1'b0;
        end else begin
            pending <= pending_next;
            if (accept) begin
                disp_valid <= 1'b1;
                if (rr_ptr == lane_idx_t'(NUM_LANES - 1))
                    rr_ptr <= '0;
                else
                    rr_ptr <= rr_ptr + 1'b1;
            end else if (disp_xfer) begin
                disp_valid <= 1'b0;
            end
        end
    end

    // operands come straight from the committed register file
    always_ff @(posedge clk) begin
        if (accept) begin
            disp_lane     <= rr_ptr;
            disp_op.instr <= in_instr;
            disp_op.a     <= read_reg(regval, rs1);
            disp_op.b     <= read_reg(regval, rs2);
            disp_op.iswb  <= iswb;
            disp_op.isld  <= isld;
            disp_use_a    <= use_rs1;
            disp_use_b    <= use_rs2;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_in_valid[i] = disp_valid && (disp_lane == lane_idx_t'(i));
            lane_in[i]       = disp_op;
        end
    end

    // a source register named by the dispatched op saw no write while it waited
    a_no_pending_operand: assert property (
        @(posedge clk) disable iff (reset)
        disp_xfer |-> (!disp_use_a || disp_op.a == read_reg(regval, rs1_of(disp_op.instr)))
                   && (!disp_use_b || disp_op.b == read_reg(regval, rs2_of(disp_op.instr)))
    );

    // writeback must only ever release a register that is in flight
    a_commit_was_pending: assert property (
        @(posedge clk) disable iff (reset)
        commit.valid |-> pending[commit.idx]
    );

endmodule

//--- verilog/cpu16_pkg.sv
package cpu16_pkg;

    localparam int WORD_W    = 16;
    localparam int NUM_REGS  = 8;
    localparam int NUM_LANES = 2;
    localparam int MEM_WORDS = 256;
    localparam int LANE_W    = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int REGVAL_W  = NUM_REGS * WORD_W;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [15:0]         instr_t;
    typedef logic [2:0]          reg_idx_t;
    typedef logic [7:0]          mem_addr_t;
    typedef logic [LANE_W-1:0]   lane_idx_t;
    typedef logic [REGVAL_W-1:0] regval_t;

    // codes not listed here behave as OP_NOP
    typedef enum logic [3:0] {
        OP_ADD = 4'h0,
        OP_SUB = 4'h1,
        OP_AND = 4'h2,
        OP_OR  = 4'h3,
        OP_XOR = 4'h4,
        OP_SHL = 4'h5,
        OP_LDI = 4'h6,
        OP_LD  = 4'h7,
        OP_NOP = 4'hf
    } opcode_t;

    typedef struct packed {
        instr_t instr;
        word_t  a;
        word_t  b;
        logic   iswb;
        logic   isld;
    } issue_t;

    typedef struct packed {
        instr_t instr;
        logic   iswb;
        logic   isld;
        word_t  aluresult;
        word_t  ldresult;
    } lane_result_t;

    typedef struct packed {
        instr_t instr;
        logic   written;
        word_t  result;
    } retire_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
        word_t    value;
    } commit_t;

    // instruction field extraction
    function automatic opcode_t op_of(instr_t instr);
        return opcode_t'(instr[15:12]);
    endfunction

    function automatic reg_idx_t rd_of(instr_t instr);
        return instr[10:8];
    endfunction

    function automatic reg_idx_t rs1_of(instr_t instr);
        return instr[7:5];
    endfunction

    function automatic reg_idx_t rs2_of(instr_t instr);
        return instr[4:2];
    endfunction

    function automatic logic [4:0] imm5_of(instr_t instr);
        return instr[4:0];
    endfunction

    function automatic logic [7:0] imm8_of(instr_t instr);
        return instr[7:0];
    endfunction

    // register 0 sits in the low word of the packed view
    function automatic word_t read_reg(regval_t rv, reg_idx_t idx);
        return rv[idx*WORD_W +: WORD_W];
    endfunction

endpackage
